// File: bus_arb_pkg.sv
// Shared constants for the bus front end; the case logic in the arbiter assumes exactly 4 clients
`default_nettype none

package bus_arb_pkg;

    // Clients per lane
    // The arbiter priority case and the grant vectors are written for this count
    localparam int num_clients = 4;

    // Width of a client index inside one lane
    localparam int client_id_w = 2;

    // Lane served on the bus
    // Also the merger's record of the last lane it served
    typedef enum logic {
        lane_rd = 1'b0,
        lane_wr = 1'b1
    } lane_e;

endpackage

`default_nettype wire

// File: prio_mux_arb.sv
// Fixed-priority 4-client arbiter with payload mux; 3-cycle latency, no back-pressure, losers not held
`timescale 1ns/1ns
`default_nettype none

module prio_mux_arb #(
    parameter type payload_t = logic [15:0]
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [bus_arb_pkg::num_clients-1:0] req,
    input  payload_t                            payload [bus_arb_pkg::num_clients],
    output logic [bus_arb_pkg::num_clients-1:0] grant,
    output payload_t                            grant_payload
);

    // Stage 1: sampled requests and payloads
    logic [bus_arb_pkg::num_clients-1:0] req_s1;
    payload_t                            payload_s1 [bus_arb_pkg::num_clients];
    logic                                valid_s1;

    // Stage 2: resolved winner
    logic [bus_arb_pkg::num_clients-1:0] grant_s2;
    payload_t                            payload_s2;
    logic                                valid_s2;

    // Combinational winner selection from stage 1
    logic [bus_arb_pkg::num_clients-1:0] sel_grant;
    payload_t                            sel_payload;

    // Lowest index wins
    always_comb begin
        sel_grant   = '0;
        sel_payload = '0;
        case (1'b1)
            req_s1[0]: begin
                sel_grant   = 4'b0001;
                sel_payload = payload_s1[0];
            end
            req_s1[1]: begin
                sel_grant   = 4'b0010;
                sel_payload = payload_s1[1];
            end
            req_s1[2]: begin
                sel_grant   = 4'b0100;
                sel_payload = payload_s1[2];
            end
            req_s1[3]: begin
                sel_grant   = 4'b1000;
                sel_payload = payload_s1[3];
            end
            default: begin
                sel_grant   = '0;
                sel_payload = '0;
            end
        endcase
    end

    // Control pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_s1        <= '0;
            valid_s1      <= 1'b0;
            grant_s2      <= '0;
            valid_s2      <= 1'b0;
            grant         <= '0;
            grant_payload <= '0;
        end else begin
            req_s1   <= req;
            valid_s1 <= |req;
            // Stage 2 keeps its last winner through empty cycles
            if (valid_s1) begin
                grant_s2 <= sel_grant;
            end
            valid_s2 <= valid_s1;
            // Output masks the held stage 2 value when idle
            if (valid_s2) begin
                grant         <= grant_s2;
                grant_payload <= payload_s2;
            end else begin
                grant         <= '0;
                grant_payload <= '0;
            end
        end
    end

    // Payload pipeline
    always_ff @(posedge clk) begin
        for (int i = 0; i < bus_arb_pkg::num_clients; i++) begin
            payload_s1[i] <= payload[i];
        end
        if (valid_s1) begin
            payload_s2 <= sel_payload;
        end
    end

endmodule

`default_nettype wire

// File: lane_merge.sv
// Merges read and write lane winners onto one bus, alternating on ties; a losing lane is dropped, not queued
`timescale 1ns/1ns
`default_nettype none

module lane_merge #(
    parameter int addr_w = 16,
    parameter int data_w = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [bus_arb_pkg::num_clients-1:0] rd_grant,
    input  logic [addr_w-1:0]                   rd_payload,
    input  logic [bus_arb_pkg::num_clients-1:0] wr_grant,
    input  logic [addr_w+data_w-1:0]            wr_payload,
    output logic                                bus_valid,
    output bus_arb_pkg::lane_e                  bus_lane,
    output logic [bus_arb_pkg::client_id_w-1:0] bus_client,
    output logic [addr_w-1:0]                   bus_addr,
    output logic [data_w-1:0]                   bus_wdata
);

    // Lane valids come straight from the grants
    logic rd_valid;
    logic wr_valid;

    logic [bus_arb_pkg::client_id_w-1:0] rd_client;
    logic [bus_arb_pkg::client_id_w-1:0] wr_client;

    // Write payload fields, address in the upper bits
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;

    logic serve_rd;
    logic serve_wr;

    // Last lane that reached the bus
    bus_arb_pkg::lane_e last_lane;

    // One-hot grant to client index
    function automatic logic [bus_arb_pkg::client_id_w-1:0] onehot_to_idx(
        input logic [bus_arb_pkg::num_clients-1:0] oh
    );
        logic [bus_arb_pkg::client_id_w-1:0] idx;
        idx = '0;
        for (int i = 0; i < bus_arb_pkg::num_clients; i++) begin
            if (oh[i]) begin
                idx = i[bus_arb_pkg::client_id_w-1:0];
            end
        end
        return idx;
    endfunction

    assign rd_valid  = |rd_grant;
    assign wr_valid  = |wr_grant;
    assign rd_client = onehot_to_idx(rd_grant);
    assign wr_client = onehot_to_idx(wr_grant);
    assign wr_addr   = wr_payload[addr_w+data_w-1:data_w];
    assign wr_data   = wr_payload[data_w-1:0];

    // On a tie, read goes unless read was the last lane served
    assign serve_rd = rd_valid && (!wr_valid || last_lane == bus_arb_pkg::lane_wr);
    assign serve_wr = wr_valid && !serve_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_valid  <= 1'b0;
            bus_lane   <= bus_arb_pkg::lane_rd;
            bus_client <= '0;
            bus_addr   <= '0;
            bus_wdata  <= '0;
            // First tie after reset goes to read
            last_lane  <= bus_arb_pkg::lane_wr;
        end else if (serve_rd) begin
            bus_valid  <= 1'b1;
            bus_lane   <= bus_arb_pkg::lane_rd;
            bus_client <= rd_client;
            bus_addr   <= rd_payload;
            bus_wdata  <= '0;
            last_lane  <= bus_arb_pkg::lane_rd;
        end else if (serve_wr) begin
            bus_valid  <= 1'b1;
            bus_lane   <= bus_arb_pkg::lane_wr;
            bus_client <= wr_client;
            bus_addr   <= wr_addr;
            bus_wdata  <= wr_data;
            last_lane  <= bus_arb_pkg::lane_wr;
        end else begin
            // Idle cycle, record unchanged
            bus_valid  <= 1'b0;
            bus_lane   <= bus_arb_pkg::lane_rd;
            bus_client <= '0;
            bus_addr   <= '0;
            bus_wdata  <= '0;
        end
    end

endmodule

`default_nettype wire

// File: bus_arb_top.sv
// Memory-bus front end for 4 read and 4 write clients; grants after 3 cycles, bus after 4, no ready/stall
`timescale 1ns/1ns
`default_nettype none

module bus_arb_top #(
    parameter int addr_w = 16,
    parameter int data_w = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,

    // Read clients
    input  logic [bus_arb_pkg::num_clients-1:0] rd_req,
    input  logic [addr_w-1:0]                   rd_addr [bus_arb_pkg::num_clients],

    // Write clients
    input  logic [bus_arb_pkg::num_clients-1:0] wr_req,
    input  logic [addr_w-1:0]                   wr_addr [bus_arb_pkg::num_clients],
    input  logic [data_w-1:0]                   wr_data [bus_arb_pkg::num_clients],

    // Local grants back to the clients
    output logic [bus_arb_pkg::num_clients-1:0] rd_grant,
    output logic [bus_arb_pkg::num_clients-1:0] wr_grant,

    // Bus side
    output logic                                bus_valid,
    output bus_arb_pkg::lane_e                  bus_lane,
    output logic [bus_arb_pkg::client_id_w-1:0] bus_client,
    output logic [addr_w-1:0]                   bus_addr,
    output logic [data_w-1:0]                   bus_wdata
);

    // Packed write payloads, address above data
    logic [addr_w+data_w-1:0] wr_payload [bus_arb_pkg::num_clients];

    // Lane winners
    logic [addr_w-1:0]        rd_win_payload;
    logic [addr_w+data_w-1:0] wr_win_payload;

    for (genvar i = 0; i < bus_arb_pkg::num_clients; i++) begin : g_wr_pack
        assign wr_payload[i] = {wr_addr[i], wr_data[i]};
    end

    prio_mux_arb #(
        .payload_t (logic [addr_w-1:0])
    ) rd_arb_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (rd_req),
        .payload       (rd_addr),
        .grant         (rd_grant),
        .grant_payload (rd_win_payload)
    );

    prio_mux_arb #(
        .payload_t (logic [addr_w+data_w-1:0])
    ) wr_arb_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (wr_req),
        .payload       (wr_payload),
        .grant         (wr_grant),
        .grant_payload (wr_win_payload)
    );

    // Read/write alternation onto the single bus
    lane_merge #(
        .addr_w (addr_w),
        .data_w (data_w)
    ) lane_merge_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_grant   (rd_grant),
        .rd_payload (rd_win_payload),
        .wr_grant   (wr_grant),
        .wr_payload (wr_win_payload),
        .bus_valid  (bus_valid),
        .bus_lane   (bus_lane),
        .bus_client (bus_client),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata)
    );

endmodule

`default_nettype wire

// File: bus_arb_chk.sv
// Bound into bus_arb_top; checks are disabled while rst_n is low
`timescale 1ns/1ns
`default_nettype none

module bus_arb_chk #(
    parameter int data_w = 16
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic [bus_arb_pkg::num_clients-1:0] rd_grant,
    input logic [bus_arb_pkg::num_clients-1:0] wr_grant,
    input logic                                bus_valid,
    input bus_arb_pkg::lane_e                  bus_lane,
    input logic [data_w-1:0]                   bus_wdata
);

    // At most one winner per lane
    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rd_grant) && $onehot0(wr_grant))
        else $error("lane grant has more than one bit set");

    // A bus beat needs a lane winner the cycle before
    valid_source: assert property (@(posedge clk) disable iff (!rst_n)
        bus_valid |-> $past((rd_grant != '0) || (wr_grant != '0)))
        else $error("bus_valid high without a lane grant one cycle earlier");

    rd_no_data: assert property (@(posedge clk) disable iff (!rst_n)
        bus_lane == bus_arb_pkg::lane_rd |-> bus_wdata == '0)
        else $error("bus_wdata nonzero on a read lane beat");

endmodule

bind bus_arb_top bus_arb_chk #(
    .data_w (data_w)
) bus_arb_chk_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_grant  (rd_grant),
    .wr_grant  (wr_grant),
    .bus_valid (bus_valid),
    .bus_lane  (bus_lane),
    .bus_wdata (bus_wdata)
);

`default_nettype wire

// File: bus_arb_tb.sv
// Self-checking testbench with seed 26 random traffic; assumes 16-bit address and data, one merged bus
`timescale 1ns/1ns
`default_nettype none

module bus_arb_tb;

    localparam int addr_w       = 16;
    localparam int data_w       = 16;
    localparam int nc           = bus_arb_pkg::num_clients;
    localparam int clk_period   = 20;
    localparam int reset_cycles = 8;
    localparam int mix_cycles   = 2000;
    // Reset, directed phases, random mix and drain tail
    localparam int total_cycles = reset_cycles + 600 + mix_cycles + 10;
    localparam int bus_w        = 2 + bus_arb_pkg::client_id_w + addr_w + data_w;

    logic                                clk;
    logic                                rst_n;
    logic [nc-1:0]                       rd_req;
    logic [addr_w-1:0]                   rd_addr [nc];
    logic [nc-1:0]                       wr_req;
    logic [addr_w-1:0]                   wr_addr [nc];
    logic [data_w-1:0]                   wr_data [nc];
    logic [nc-1:0]                       rd_grant;
    logic [nc-1:0]                       wr_grant;
    logic                                bus_valid;
    bus_arb_pkg::lane_e                  bus_lane;
    logic [bus_arb_pkg::client_id_w-1:0] bus_client;
    logic [addr_w-1:0]                   bus_addr;
    logic [data_w-1:0]                   bus_wdata;

    // Expected grants {rd, wr} and bus words {valid, lane, client, addr, wdata}
    logic [2*nc-1:0]    grant_q [$];
    logic [bus_w-1:0]   bus_q [$];
    string              grant_name_q [$];
    string              bus_name_q [$];
    bus_arb_pkg::lane_e model_last;
    string              test_name;
    int                 grant_errors;
    int                 bus_errors;
    int                 other_errors;
    int                 bus_beats;

    bus_arb_top #(
        .addr_w (addr_w),
        .data_w (data_w)
    ) bus_arb_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    // Lowest requesting index or -1 when nobody asks
    function automatic int winner(input logic [nc-1:0] req);
        for (int i = 0; i < nc; i++) begin
            if (req[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_grant(input string name, input string lane,
                               input logic [nc-1:0] exp, input logic [nc-1:0] act);
        if (act !== exp) begin
            grant_errors++;
            $display("mismatch %s %s grant: expected %b actual %b at %0t",
                     name, lane, exp, act, $time);
        end
    endtask

    task automatic check_bus(input string name, input logic exp_valid,
                             input bus_arb_pkg::lane_e exp_lane,
                             input logic [bus_arb_pkg::client_id_w-1:0] exp_client,
                             input logic [addr_w-1:0] exp_addr,
                             input logic [data_w-1:0] exp_wdata);
        if ({bus_valid, bus_lane, bus_client, bus_addr, bus_wdata} !==
            {exp_valid, exp_lane, exp_client, exp_addr, exp_wdata}) begin
            bus_errors++;
            $display(
                "mismatch %s bus: expected v=%b %s c=%0d a=%h d=%h actual v=%b %s c=%0d a=%h d=%h",
                name, exp_valid, exp_lane.name(), exp_client, exp_addr, exp_wdata,
                bus_valid, bus_lane.name(), bus_client, bus_addr, bus_wdata);
        end
    endtask

    // One cycle of requests with fresh random payloads
    task automatic drive(input string name, input logic [nc-1:0] rd, input logic [nc-1:0] wr);
        @(posedge clk);
        #2;
        test_name = name;
        rd_req    = rd;
        wr_req    = wr;
        for (int i = 0; i < nc; i++) begin
            rd_addr[i] = addr_w'($urandom);
            wr_addr[i] = addr_w'($urandom);
            wr_data[i] = data_w'($urandom);
        end
    endtask

    function automatic logic [nc-1:0] busy_req();
        return nc'($urandom_range(1, (1 << nc) - 1));
    endfunction

    // Reference model on the inputs sampled at each rising edge
    always @(posedge clk) begin : ref_model
        int                 rw;
        int                 ww;
        bus_arb_pkg::lane_e serve;
        logic [bus_w-1:0]   bw;
        if (!rst_n) begin
            grant_q.delete();
            bus_q.delete();
            grant_name_q.delete();
            bus_name_q.delete();
            model_last = bus_arb_pkg::lane_wr;
        end else begin
            rw = winner(rd_req);
            ww = winner(wr_req);
            bw = '0;
            if (rw >= 0 && ww >= 0) begin
                // Tie goes to the lane not served last
                serve = (model_last == bus_arb_pkg::lane_rd) ? bus_arb_pkg::lane_wr
                                                              : bus_arb_pkg::lane_rd;
            end else begin
                serve = (rw >= 0) ? bus_arb_pkg::lane_rd : bus_arb_pkg::lane_wr;
            end
            if (rw >= 0 && serve == bus_arb_pkg::lane_rd) begin
                bw = {1'b1, bus_arb_pkg::lane_rd, rw[bus_arb_pkg::client_id_w-1:0],
                      rd_addr[rw], {data_w{1'b0}}};
                model_last = serve;
            end else if (ww >= 0 && serve == bus_arb_pkg::lane_wr) begin
                bw = {1'b1, bus_arb_pkg::lane_wr, ww[bus_arb_pkg::client_id_w-1:0],
                      wr_addr[ww], wr_data[ww]};
                model_last = serve;
            end
            grant_q.push_back({(rw < 0) ? nc'(0) : nc'(1 << rw),
                               (ww < 0) ? nc'(0) : nc'(1 << ww)});
            grant_name_q.push_back(test_name);
            bus_q.push_back(bw);
            bus_name_q.push_back(test_name);
        end
    end

    // The oldest entry is due once the grant queue holds 3 and the bus queue 4
    always @(negedge clk) begin : compare
        logic [2*nc-1:0]  eg;
        logic [bus_w-1:0] eb;
        string            gn;
        string            bn;
        eg = '0;
        eb = '0;
        gn = "reset";
        bn = "reset";
        if (grant_q.size() >= 3) begin
            eg = grant_q.pop_front();
            gn = grant_name_q.pop_front();
        end
        if (bus_q.size() >= 4) begin
            eb = bus_q.pop_front();
            bn = bus_name_q.pop_front();
        end
        check_grant(gn, "rd", eg[2*nc-1:nc], rd_grant);
        check_grant(gn, "wr", eg[nc-1:0], wr_grant);
        check_bus(bn, eb[bus_w-1], bus_arb_pkg::lane_e'(eb[bus_w-2]),
                  eb[bus_w-3:addr_w+data_w], eb[addr_w+data_w-1:data_w], eb[data_w-1:0]);
        if (bus_valid) begin
            bus_beats++;
        end
    end

    initial begin
        void'($urandom(26));
        test_name    = "reset";
        grant_errors = 0;
        bus_errors   = 0;
        other_errors = 0;
        bus_beats    = 0;
        rst_n        = 1'b0;
        rd_req       = '0;
        wr_req       = '0;
        for (int i = 0; i < nc; i++) begin
            rd_addr[i] = '0;
            wr_addr[i] = '0;
            wr_data[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Contention first so the first tie after reset is seen
        repeat (100) drive("contention", busy_req(), busy_req());
        repeat (200) drive("priority", nc'($urandom), nc'($urandom));
        repeat (100) drive("read_only", nc'($urandom), '0);
        repeat (100) drive("write_only", '0, nc'($urandom));
        for (int i = 0; i < 100; i++) begin
            drive("idle_gaps", (i % 3 == 1) ? '0 : busy_req(), (i % 3 == 1) ? '0 : busy_req());
        end
        repeat (mix_cycles) drive("random_mix", nc'($urandom), nc'($urandom));
        repeat (10) drive("drain", '0, '0);
        if (bus_beats == 0) begin
            other_errors++;
            $display("bus_valid never went high during the run");
        end
        $display("grant errors: %0d  bus errors: %0d  other errors: %0d",
                 grant_errors, bus_errors, other_errors);
        if (grant_errors + bus_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((total_cycles + 50) * clk_period);
        $display("watchdog expired, stimulus did not finish within %0d cycles", total_cycles + 50);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
bus_arb_pkg.sv
prio_mux_arb.sv
lane_merge.sv
bus_arb_top.sv
bus_arb_chk.sv
bus_arb_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module bus_arb_tb \
    --Mdir obj_dir -o sim_bus_arb

# Keep the output even when the simulator exits with an error status
sim_out=$(./obj_dir/sim_bus_arb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "simulation did not report success" >&2
exit 1
